//--- source/cpuPkg.sv
// Core package for the RV32I out-of-order-complete core
// Shared word, index and tag types plus opcode and ALU codes
package cpuPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [1:0]  robId_t;
  typedef logic [3:0]  aluOp_t;

  // Reorder buffer entries, must match the robId_t range
  localparam int ROB_DEPTH = 4;

  // Major opcodes handled by decode
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;

  // ALU operation codes
  localparam aluOp_t ALU_ADD   = 4'd0;
  localparam aluOp_t ALU_SUB   = 4'd1;
  localparam aluOp_t ALU_SLL   = 4'd2;
  localparam aluOp_t ALU_SLT   = 4'd3;
  localparam aluOp_t ALU_SLTU  = 4'd4;
  localparam aluOp_t ALU_XOR   = 4'd5;
  localparam aluOp_t ALU_SRL   = 4'd6;
  localparam aluOp_t ALU_SRA   = 4'd7;
  localparam aluOp_t ALU_OR    = 4'd8;
  localparam aluOp_t ALU_AND   = 4'd9;
  localparam aluOp_t ALU_PASSB = 4'd10;

  // Fetch handshake states
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAITDROP,
    HOLD
  } fetchState_t;

endpackage

//--- source/issueIf.sv
// Dispatch bus from decode to the ALU and the reorder buffer
`timescale 1ns/1ps

interface issueIf;
  import cpuPkg::*;

  logic    valid;
  robId_t  robId;
  aluOp_t  op;
  word_t   operandA;
  word_t   operandB;
  regIdx_t dest;

  modport source (
    output valid, robId, op, operandA, operandB, dest
  );

  modport sink (
    input valid, robId, op, operandA, operandB, dest
  );

endinterface

//--- source/commitIf.sv
// Retirement bus from the reorder buffer to the register file
`timescale 1ns/1ps

interface commitIf;
  import cpuPkg::*;

  logic    valid;
  regIdx_t dest;
  robId_t  robId;
  word_t   value;

  modport source (output valid, dest, robId, value);

  modport sink (input valid, dest, robId, value);

endinterface

//--- source/instructionUnit.sv
// Instruction unit with four-phase fetch, decode and dispatch
// Stalls on a full reorder buffer or a busy source register
`timescale 1ns/1ps

module instructionUnit (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  input  logic            instrAck,
  input  cpuPkg::word_t   instrData,
  input  logic            robFull,
  input  cpuPkg::robId_t  robTail,
  input  logic            rs1Busy,
  input  logic            rs2Busy,
  input  cpuPkg::word_t   rs1Value,
  input  cpuPkg::word_t   rs2Value,
  output logic            instrReq,
  output cpuPkg::word_t   instrAddr,
  output cpuPkg::regIdx_t rs1Idx,
  output cpuPkg::regIdx_t rs2Idx,
  issueIf.source          issue
);
  import cpuPkg::*;

  fetchState_t state;
  word_t       pc;
  word_t       instrReg;
  word_t       instrPc;
  logic        heldValid;

  aluOp_t aluOp;
  word_t  opA;
  word_t  opB;
  logic   writesRd;
  logic   usesRs1;
  logic   usesRs2;
  logic   stall;
  logic   dispatch;

  // Map funct3 to an ALU op; alt is instr[30]
  function automatic aluOp_t decodeFunct(input logic [2:0] f3, input logic alt,
                                         input logic isReg);
    aluOp_t res;
    case (f3)
      3'b000:  res = (isReg && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  res = ALU_SLL;
      3'b010:  res = ALU_SLT;
      3'b011:  res = ALU_SLTU;
      3'b100:  res = ALU_XOR;
      3'b101:  res = alt ? ALU_SRA : ALU_SRL;
      3'b110:  res = ALU_OR;
      default: res = ALU_AND;
    endcase
    return res;
  endfunction

  assign instrReq  = (state == REQ);
  assign instrAddr = pc;
  assign rs1Idx    = instrReg[19:15];
  assign rs2Idx    = instrReg[24:20];

  always_comb
  begin
    aluOp    = ALU_PASSB;
    opA      = '0;
    opB      = '0;
    writesRd = 1'b0;
    usesRs1  = 1'b0;
    usesRs2  = 1'b0;
    case (instrReg[6:0])
      OPC_OP:
      begin
        aluOp    = decodeFunct(instrReg[14:12], instrReg[30], 1'b1);
        opA      = rs1Value;
        opB      = rs2Value;
        writesRd = 1'b1;
        usesRs1  = 1'b1;
        usesRs2  = 1'b1;
      end
      OPC_OPIMM:
      begin
        aluOp    = decodeFunct(instrReg[14:12], instrReg[30], 1'b0);
        opA      = rs1Value;
        opB      = {{20{instrReg[31]}}, instrReg[31:20]};
        writesRd = 1'b1;
        usesRs1  = 1'b1;
      end
      OPC_LUI:
      begin
        opB      = {instrReg[31:12], 12'b0};
        writesRd = 1'b1;
      end
      OPC_AUIPC:
      begin
        aluOp    = ALU_ADD;
        opA      = instrPc;
        opB      = {instrReg[31:12], 12'b0};
        writesRd = 1'b1;
      end
      // Anything else retires as a no-op to x0
      default: ;
    endcase
  end

  assign stall    = robFull || (usesRs1 && rs1Busy) || (usesRs2 && rs2Busy);
  assign dispatch = heldValid && rdy_in && !stall;

  assign issue.valid    = dispatch;
  assign issue.robId    = robTail;
  assign issue.op       = aluOp;
  assign issue.operandA = opA;
  assign issue.operandB = opB;
  assign issue.dest     = writesRd ? instrReg[11:7] : '0;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state     <= IDLE;
      pc        <= '0;
      heldValid <= 1'b0;
    end
    else if (rdy_in)
    begin
      if (dispatch)
        heldValid <= 1'b0;
      case (state)
        IDLE: state <= REQ;
        REQ:
        begin
          if (instrAck)
          begin
            instrReg  <= instrData;
            instrPc   <= pc;
            pc        <= pc + 32'd4;
            heldValid <= 1'b1;
            state     <= WAITDROP;
          end
        end
        // Memory must release ack before the next request
        WAITDROP:
        begin
          if (!instrAck)
            state <= HOLD;
        end
        default:
        begin
          if (!heldValid || dispatch)
            state <= REQ;
        end
      endcase
    end
  end

endmodule

//--- source/registerFile.sv
// Architectural register file with busy bits and producer tags
`timescale 1ns/1ps

module registerFile (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  input  cpuPkg::regIdx_t rs1Idx,
  input  cpuPkg::regIdx_t rs2Idx,
  output cpuPkg::word_t   rs1Value,
  output cpuPkg::word_t   rs2Value,
  output logic            rs1Busy,
  output logic            rs2Busy,
  issueIf.sink            issue,
  commitIf.sink           commit
);
  import cpuPkg::*;

  word_t       regs [32];
  robId_t      tag [32];
  logic [31:0] busy;
  logic        fwd1;
  logic        fwd2;

  // Same-cycle commit bypass
  assign fwd1 = commit.valid && (commit.dest == rs1Idx) && (rs1Idx != '0);
  assign fwd2 = commit.valid && (commit.dest == rs2Idx) && (rs2Idx != '0);

  assign rs1Value = (rs1Idx == '0) ? '0 : (fwd1 ? commit.value : regs[rs1Idx]);
  assign rs2Value = (rs2Idx == '0) ? '0 : (fwd2 ? commit.value : regs[rs2Idx]);

  // Released only when the retiring entry is the latest producer
  assign rs1Busy = busy[rs1Idx] && !(fwd1 && (commit.robId == tag[rs1Idx]));
  assign rs2Busy = busy[rs2Idx] && !(fwd2 && (commit.robId == tag[rs2Idx]));

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      busy <= '0;
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (rdy_in)
    begin
      if (commit.valid && (commit.dest != '0))
      begin
        regs[commit.dest] <= commit.value;
        if (tag[commit.dest] == commit.robId)
          busy[commit.dest] <= 1'b0;
      end
      // A new producer overrides a release in the same cycle
      if (issue.valid && (issue.dest != '0))
      begin
        busy[issue.dest] <= 1'b1;
        tag[issue.dest]  <= issue.robId;
      end
    end
  end

endmodule

//--- source/aluUnit.sv
// Two-stage integer ALU, operands registered then result registered
`timescale 1ns/1ps

module aluUnit (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           rdy_in,
  issueIf.sink           issue,
  output logic           resultValid,
  output cpuPkg::robId_t resultRobId,
  output cpuPkg::word_t  resultValue
);
  import cpuPkg::*;

  logic   s1Valid;
  robId_t s1RobId;
  aluOp_t s1Op;
  word_t  s1A;
  word_t  s1B;
  word_t  aluOut;

  always_comb
  begin
    case (s1Op)
      ALU_ADD:   aluOut = s1A + s1B;
      ALU_SUB:   aluOut = s1A - s1B;
      ALU_SLL:   aluOut = s1A << s1B[4:0];
      ALU_SLT:   aluOut = {31'b0, $signed(s1A) < $signed(s1B)};
      ALU_SLTU:  aluOut = {31'b0, s1A < s1B};
      ALU_XOR:   aluOut = s1A ^ s1B;
      ALU_SRL:   aluOut = s1A >> s1B[4:0];
      ALU_SRA:   aluOut = $signed(s1A) >>> s1B[4:0];
      ALU_OR:    aluOut = s1A | s1B;
      ALU_AND:   aluOut = s1A & s1B;
      ALU_PASSB: aluOut = s1B;
      default:   aluOut = '0;
    endcase
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      s1Valid     <= 1'b0;
      resultValid <= 1'b0;
    end
    else if (rdy_in)
    begin
      // Stage one
      s1Valid <= issue.valid;
      s1RobId <= issue.robId;
      s1Op    <= issue.op;
      s1A     <= issue.operandA;
      s1B     <= issue.operandB;
      // Stage two
      resultValid <= s1Valid;
      resultRobId <= s1RobId;
      resultValue <= aluOut;
    end
  end

endmodule

//--- source/reorderBuffer.sv
// Four-entry reorder buffer that retires the head in program order
// Drives the register file commit bus and the external commit port
`timescale 1ns/1ps

module reorderBuffer (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  issueIf.sink            issue,
  input  logic            resultValid,
  input  cpuPkg::robId_t  resultRobId,
  input  cpuPkg::word_t   resultValue,
  output cpuPkg::robId_t  robTail,
  output logic            robFull,
  commitIf.source         commit,
  output logic            commitValid,
  output cpuPkg::regIdx_t commitDest,
  output cpuPkg::word_t   commitValue
);
  import cpuPkg::*;

  typedef logic [$clog2(ROB_DEPTH):0] count_t;

  regIdx_t              entryDest [ROB_DEPTH];
  word_t                entryValue [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] entryDone;
  robId_t               head;
  robId_t               tail;
  count_t               count;
  logic                 retire;

  assign retire  = rdy_in && (count != '0) && entryDone[head];
  assign robTail = tail;
  assign robFull = (count == count_t'(ROB_DEPTH));

  assign commit.valid = retire;
  assign commit.dest  = entryDest[head];
  assign commit.robId = head;
  assign commit.value = entryValue[head];

  // External port mirrors the retirement
  assign commitValid = retire;
  assign commitDest  = entryDest[head];
  assign commitValue = entryValue[head];

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      entryDone <= '0;
    end
    else if (rdy_in)
    begin
      if (issue.valid)
      begin
        entryDest[issue.robId] <= issue.dest;
        entryDone[issue.robId] <= 1'b0;
        tail                   <= tail + 2'd1;
      end
      if (resultValid)
      begin
        entryDone[resultRobId]  <= 1'b1;
        entryValue[resultRobId] <= resultValue;
      end
      if (retire)
        head <= head + 2'd1;
      count <= count + count_t'(issue.valid) - count_t'(retire);
    end
  end

endmodule

//--- source/cpu.sv
// RV32I core top level, fetch port in and commit port out
`timescale 1ns/1ps

module cpu (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  output logic            instrReq,
  output cpuPkg::word_t   instrAddr,
  input  logic            instrAck,
  input  cpuPkg::word_t   instrData,
  output logic            commitValid,
  output cpuPkg::regIdx_t commitDest,
  output cpuPkg::word_t   commitValue
);
  import cpuPkg::*;

  issueIf  issueBus ();
  commitIf commitBus ();

  regIdx_t rs1Idx;
  regIdx_t rs2Idx;
  word_t   rs1Value;
  word_t   rs2Value;
  logic    rs1Busy;
  logic    rs2Busy;
  robId_t  robTail;
  logic    robFull;
  logic    resultValid;
  robId_t  resultRobId;
  word_t   resultValue;

  instructionUnit u_instructionUnit (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .instrAck  (instrAck),
    .instrData (instrData),
    .robFull   (robFull),
    .robTail   (robTail),
    .rs1Busy   (rs1Busy),
    .rs2Busy   (rs2Busy),
    .rs1Value  (rs1Value),
    .rs2Value  (rs2Value),
    .instrReq  (instrReq),
    .instrAddr (instrAddr),
    .rs1Idx    (rs1Idx),
    .rs2Idx    (rs2Idx),
    .issue     (issueBus.source)
  );

  registerFile u_registerFile (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .rdy_in   (rdy_in),
    .rs1Idx   (rs1Idx),
    .rs2Idx   (rs2Idx),
    .rs1Value (rs1Value),
    .rs2Value (rs2Value),
    .rs1Busy  (rs1Busy),
    .rs2Busy  (rs2Busy),
    .issue    (issueBus.sink),
    .commit   (commitBus.sink)
  );

  aluUnit u_aluUnit (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .issue       (issueBus.sink),
    .resultValid (resultValid),
    .resultRobId (resultRobId),
    .resultValue (resultValue)
  );

  reorderBuffer u_reorderBuffer (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .issue       (issueBus.sink),
    .resultValid (resultValid),
    .resultRobId (resultRobId),
    .resultValue (resultValue),
    .robTail     (robTail),
    .robFull     (robFull),
    .commit      (commitBus.source),
    .commitValid (commitValid),
    .commitDest  (commitDest),
    .commitValue (commitValue)
  );

endmodule

//--- bench/cpu_assert.sv
// Handshake and reset checks bound onto the core top level
`timescale 1ns/1ps

module cpuAssert (
  input logic clk_in,
  input logic rst_in,
  input logic rdy_in,
  input logic instrReq,
  input logic instrAck,
  input logic commitValid
);

  int failCount = 0;

  // Request stays up until memory answers
  reqHeld: assert property (@(posedge clk_in) disable iff (rst_in)
    instrReq && !instrAck |=> instrReq)
  else
  begin
    $error("instrReq dropped before instrAck");
    failCount++;
  end

  ackAfterReq: assert property (@(posedge clk_in) disable iff (rst_in)
    $rose(instrAck) |-> instrReq)
  else
  begin
    $error("instrAck rose while instrReq was low");
    failCount++;
  end

  // Empty reorder buffer right after reset
  quietAfterReset: assert property (@(posedge clk_in)
    rst_in |=> !commitValid)
  else
  begin
    $error("commitValid high in the cycle after reset");
    failCount++;
  end

  // Pause freezes the fetch request level
  reqFrozenPaused: assert property (@(posedge clk_in) disable iff (rst_in)
    !rdy_in |=> $stable(instrReq))
  else
  begin
    $error("instrReq changed while rdy_in low");
    failCount++;
  end

endmodule

bind cpu cpuAssert u_cpuAssert (
  .clk_in      (clk_in),
  .rst_in      (rst_in),
  .rdy_in      (rdy_in),
  .instrReq    (instrReq),
  .instrAck    (instrAck),
  .commitValid (commitValid)
);

//--- bench/cpuTb.sv
// Testbench for the RV32I core with a table-driven program
// Serves fetches with random ack delays and checks each commit in order
`timescale 1ns/1ps

module cpuTb;

  localparam int NUM_ROWS        = 33;
  localparam int WATCHDOG_CYCLES = (NUM_ROWS + 10) * 40;
  localparam int PAUSE_AFTER     = 21;
  localparam int PAUSE_CYCLES    = 12;
  localparam logic [31:0] NOP    = 32'h0000_0013;

  logic        clk_in;
  logic        rst_in;
  logic        rdy_in;
  logic        instrReq;
  logic [31:0] instrAddr;
  logic        instrAck;
  logic [31:0] instrData;
  logic        commitValid;
  logic [4:0]  commitDest;
  logic [31:0] commitValue;

  string       rowName [NUM_ROWS];
  logic [31:0] rowInstr [NUM_ROWS];
  logic [4:0]  rowDest [NUM_ROWS];
  logic [31:0] rowValue [NUM_ROWS];
  int          rowCount = 0;
  int          errorCount = 0;
  int          commitsSeen = 0;
  logic [15:0] lfsrState = 16'd1735;

  cpu u_dut (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .instrReq    (instrReq),
    .instrAddr   (instrAddr),
    .instrAck    (instrAck),
    .instrData   (instrData),
    .commitValid (commitValid),
    .commitDest  (commitDest),
    .commitValue (commitValue)
  );

  initial
  begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  // Taps 16, 14, 13, 11
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic int randomDelay();
    logic hi;
    logic lo;
    hi = lfsrStep();
    lo = lfsrStep();
    return int'({hi, lo});
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  task automatic tick();
    @(posedge clk_in);
    #1;
  endtask

  task automatic addRow(input string name, input logic [31:0] instr,
                        input logic [4:0] dest, input logic [31:0] value);
    rowName[rowCount]  = name;
    rowInstr[rowCount] = instr;
    rowDest[rowCount]  = dest;
    rowValue[rowCount] = value;
    rowCount++;
  endtask

  task automatic checkValue(input string testName, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %s %s expected 0x%08h actual 0x%08h",
               testName, field, expected, actual);
      errorCount++;
    end
  endtask

  // Expected values follow the running register state by hand
  // x14 starts at 0
  task automatic buildTable();
    addRow("addi x1 5", encI(12'd5, 5'd0, 3'b000, 5'd1), 5'd1, 32'h5);
    addRow("addi x2 -3", encI(12'hFFD, 5'd0, 3'b000, 5'd2), 5'd2, 32'hFFFF_FFFD);
    addRow("slti", encI(12'd1, 5'd2, 3'b010, 5'd3), 5'd3, 32'h1);
    addRow("xori", encI(12'h0FF, 5'd1, 3'b100, 5'd4), 5'd4, 32'hFA);
    addRow("slli", encI(12'd4, 5'd1, 3'b001, 5'd5), 5'd5, 32'h50);
    addRow("srli", encI(12'd28, 5'd2, 3'b101, 5'd6), 5'd6, 32'hF);
    addRow("srai", encI(12'h401, 5'd2, 3'b101, 5'd7), 5'd7, 32'hFFFF_FFFE);
    addRow("sub", encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd8), 5'd8, 32'h8);
    addRow("sra", encR(7'h20, 5'd1, 5'd2, 3'b101, 5'd9), 5'd9, 32'hFFFF_FFFF);
    addRow("sltu", encR(7'h00, 5'd2, 5'd1, 3'b011, 5'd10), 5'd10, 32'h1);
    addRow("and", encR(7'h00, 5'd5, 5'd4, 3'b111, 5'd11), 5'd11, 32'h50);
    addRow("lui", encU(20'h12345, 5'd12, 7'b0110111), 5'd12, 32'h1234_5000);
    // Row 12 sits at address 0x30
    addRow("auipc", encU(20'h00001, 5'd13, 7'b0010111), 5'd13, 32'h0000_1030);
    addRow("chain 1", encI(12'd1, 5'd14, 3'b000, 5'd14), 5'd14, 32'h1);
    addRow("chain 2", encI(12'd1, 5'd14, 3'b000, 5'd14), 5'd14, 32'h2);
    addRow("chain 3", encI(12'd1, 5'd14, 3'b000, 5'd14), 5'd14, 32'h3);
    addRow("chain add", encR(7'h00, 5'd14, 5'd14, 3'b000, 5'd15), 5'd15, 32'h6);
    addRow("write x0", encI(12'd7, 5'd1, 3'b000, 5'd0), 5'd0, 32'h0);
    addRow("read x0", encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd16), 5'd16, 32'h0);
    for (int k = 1; k <= 6; k++)
      addRow($sformatf("indep %0d", k), encI(12'(k), 5'd0, 3'b000, 5'(16 + k)),
             5'(16 + k), 32'(k));
    addRow("ori", encI(12'h100, 5'd22, 3'b110, 5'd23), 5'd23, 32'h106);
    addRow("or", encR(7'h00, 5'd4, 5'd1, 3'b110, 5'd24), 5'd24, 32'hFF);
    addRow("srl", encR(7'h00, 5'd1, 5'd2, 3'b101, 5'd25), 5'd25, 32'h07FF_FFFF);
    addRow("sll", encR(7'h00, 5'd1, 5'd1, 3'b001, 5'd26), 5'd26, 32'hA0);
    addRow("slt", encR(7'h00, 5'd1, 5'd2, 3'b010, 5'd27), 5'd27, 32'h1);
    addRow("xor", encR(7'h00, 5'd1, 5'd2, 3'b100, 5'd28), 5'd28, 32'hFFFF_FFF8);
    addRow("andi", encI(12'h0F0, 5'd2, 3'b111, 5'd29), 5'd29, 32'hF0);
    addRow("unknown opcode", 32'h0000_000B, 5'd0, 32'h0);
  endtask

  // Outputs settle well before the falling edge
  task automatic waitCommit();
    do
    begin
      @(negedge clk_in);
      if (commitValid && !rdy_in)
      begin
        $display("Commit arrived while rdy_in was low");
        errorCount++;
      end
    end
    while (!commitValid);
  endtask

  // Memory side of the four-phase fetch handshake
  initial
  begin : fetchResponder
    int idx;
    int delay;
    forever
    begin
      tick();
      if (instrReq)
      begin
        idx = int'(instrAddr >> 2);
        delay = randomDelay();
        repeat (delay) tick();
        instrData = (idx < NUM_ROWS) ? rowInstr[idx] : NOP;
        instrAck  = 1'b1;
        while (instrReq)
          tick();
        delay = randomDelay();
        repeat (delay) tick();
        instrAck = 1'b0;
      end
    end
  end

  // Pause window in the middle of the independent run
  initial
  begin : pauseWindow
    while (commitsSeen < PAUSE_AFTER)
      tick();
    rdy_in = 1'b0;
    repeat (PAUSE_CYCLES) tick();
    rdy_in = 1'b1;
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_in);
    $display("Timeout: commits stopped arriving after %0d of %0d rows",
             commitsSeen, NUM_ROWS);
    $display("Finished with errors");
    $finish;
  end

  initial
  begin : commitChecker
    int errorsBefore;
    int assertFails;
    rst_in    = 1'b1;
    rdy_in    = 1'b1;
    instrAck  = 1'b0;
    instrData = '0;
    buildTable();
    repeat (2) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      waitCommit();
      errorsBefore = errorCount;
      checkValue(rowName[i], "dest", {27'b0, rowDest[i]}, {27'b0, commitDest});
      // Value of an x0 write is discarded
      if (rowDest[i] != 5'd0)
        checkValue(rowName[i], "value", rowValue[i], commitValue);
      commitsSeen++;
      if (errorCount == errorsBefore)
        $display("test %0d %s: ok", i, rowName[i]);
      else
        $display("test %0d %s: mismatch", i, rowName[i]);
    end
    assertFails = u_dut.u_cpuAssert.failCount;
    $display("Summary: %0d commits checked, %0d errors, %0d assertion failures",
             commitsSeen, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- sim.f
source/cpuPkg.sv
source/issueIf.sv
source/commitIf.sv
source/instructionUnit.sv
source/registerFile.sv
source/aluUnit.sv
source/reorderBuffer.sv
source/cpu.sv
bench/cpu_assert.sv
bench/cpuTb.sv

//--- Makefile
# Verilator build and run for the RV32I core testbench

VERILATOR  ?= verilator
TOP        ?= cpuTb
FILELIST   ?= sim.f
OBJDIR     ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Finished with no errors

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

sim: build
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
